/* common/fetch_pkg.sv */
// Shared widths, limits, opcode and state enums, and stage structs for the fetch/execute core
package fetch_pkg;

	////////////////////
	// Widths and limits
	////////////////////

	// Bus address and data
	localparam int unsigned ADDR_W = 32;
	localparam int unsigned DATA_W = 32;

	// Most words requested but not yet consumed
	localparam int unsigned FETCH_LIMIT = 8;

	// FIFO depth is 2**LGFIFO
	localparam int unsigned LGFIFO = 3;
	// Outstanding read counter width
	localparam int unsigned LGDEPTH = LGFIFO + 4;

	// Register file
	localparam int unsigned NREGS = 4;
	localparam int unsigned REG_W = 2;

	////////////////////
	// Enums
	////////////////////

	// Opcode field, insn[31:28]
	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_LDI  = 4'h1,
		OP_ADDI = 4'h2,
		OP_ADD  = 4'h3,
		OP_SUB  = 4'h4,
		OP_XOR  = 4'h5,
		OP_JMP  = 4'h6,
		OP_BNZ  = 4'h7,
		OP_HALT = 4'h8
	} opcode_e;

	// Machine run state
	typedef enum logic [1:0] {
		ST_RUN    = 2'd0,
		ST_HALTED = 2'd1,
		ST_TRAP   = 2'd2
	} cpu_state_e;

	////////////////////
	// Stage structs
	////////////////////

	// Fetch to decode
	typedef struct packed {
		logic [DATA_W-1:0] insn;
		logic [ADDR_W-1:0] pc;
		logic              err;
	} fetch_word_t;

	// Decode to execute
	typedef struct packed {
		logic              valid;
		opcode_e           op;
		logic [REG_W-1:0]  rd;
		logic [REG_W-1:0]  rs;
		logic [DATA_W-1:0] imm;
		logic [ADDR_W-1:0] pc;
		logic              err;
	} decoded_t;

	// Execute to result, and out of the top
	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] pc;
		logic [REG_W-1:0]  rd;
		logic [DATA_W-1:0] value;
		logic              we;
		opcode_e           op;
	} retire_t;

endpackage

/* hw/fetch/insn_fifo.sv */
`timescale 1ns/1ps
// Circular buffer for fetched instruction words and their bus-error bit
module insn_fifo
	import fetch_pkg::*;
(
	input  logic            S_AXI_ACLK,
	input  logic            i_flush,
	input  logic            i_wr,
	input  logic [DATA_W:0] i_data,
	input  logic            i_rd,
	output logic [DATA_W:0] o_data,
	output logic            o_empty,
	output logic            o_full
);

	localparam int unsigned DEPTH = 1 << LGFIFO;

	logic [DATA_W:0] mem [DEPTH];
	// Extra MSB tells full from empty
	logic [LGFIFO:0] wr_ptr;
	logic [LGFIFO:0] rd_ptr;
	logic            do_wr;
	logic            do_rd;

	assign do_wr = i_wr && !o_full;
	assign do_rd = i_rd && !o_empty;

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full = (wr_ptr[LGFIFO] != rd_ptr[LGFIFO])
		&& (wr_ptr[LGFIFO-1:0] == rd_ptr[LGFIFO-1:0]);

	// Pointers
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (do_wr)
			mem[wr_ptr[LGFIFO-1:0]] <= i_data;
	end

	// Head word, read straight out
	assign o_data = mem[rd_ptr[LGFIFO-1:0]];

	// Fetch throttle keeps writes below depth
	a_no_overflow: assert property (@(posedge S_AXI_ACLK) disable iff (i_flush)
		i_wr |-> !o_full);

endmodule

/* hw/fetch/axil_fetch.sv */
`timescale 1ns/1ps
// AXI-lite instruction fetcher, tracks outstanding reads and flushes stale words on redirect
module axil_fetch
	import fetch_pkg::*;
(
	input  logic              S_AXI_ACLK,
	input  logic              fifo_reset,
	input  logic              i_new_pc,
	input  logic [ADDR_W-1:0] i_pc,
	input  logic              i_ready,
	output fetch_word_t       o_word,
	output logic              o_valid,
	output logic              o_m_axi_arvalid,
	input  logic              i_m_axi_arready,
	output logic [ADDR_W-1:0] o_m_axi_araddr,
	input  logic              i_m_axi_rvalid,
	output logic              o_m_axi_rready,
	input  logic [DATA_W-1:0] i_m_axi_rdata,
	input  logic [1:0]        i_m_axi_rresp
);

	logic [LGDEPTH:0]   outstanding;
	logic [LGDEPTH:0]   flushcount;
	logic [LGDEPTH:0]   new_flushcount;
	logic [LGDEPTH-1:0] fill;
	logic [LGDEPTH:0]   req_load;
	logic               flushing;
	logic               full_bus;
	logic               throttle;
	logic               fetch_en;
	logic               pending_redirect;
	logic [ADDR_W-1:0]  pending_pc;
	logic               ar_hs;
	logic               fifo_clear;
	logic               fifo_wr;
	logic               fifo_rd;
	logic               fifo_empty;
	logic               fifo_full;
	logic [DATA_W:0]    fifo_rd_data;
	logic [DATA_W-1:0]  out_insn;
	logic [ADDR_W-1:0]  out_pc;
	logic               out_err;

	// Responses always taken
	assign o_m_axi_rready = 1'b1;

	assign ar_hs = o_m_axi_arvalid && i_m_axi_arready;
	// Redirect empties the buffer
	assign fifo_clear = fifo_reset || i_new_pc;
	assign fifo_wr = i_m_axi_rvalid && !flushing;
	// Pop whenever the output register is free
	assign fifo_rd = (!o_valid || i_ready) && !fifo_empty;

	////////////////////
	// Outstanding reads
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			outstanding <= '0;
		else
			case ({ar_hs, i_m_axi_rvalid})
				2'b10: outstanding <= outstanding + 1'b1;
				2'b01: outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
	end

	// Counter near wrap
	assign full_bus = outstanding >= (LGDEPTH+1)'((1 << LGDEPTH) - 1);

	// Stale reads at redirect, a held ARVALID counts too
	assign new_flushcount = outstanding + (LGDEPTH+1)'(o_m_axi_arvalid)
		- (LGDEPTH+1)'(i_m_axi_rvalid);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			flushcount <= '0;
		else if (i_new_pc)
			flushcount <= new_flushcount;
		else if (i_m_axi_rvalid && flushing)
			flushcount <= flushcount - 1'b1;
	end

	assign flushing = (flushcount != '0);

	// Live words requested and not yet popped
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_clear)
			fill <= '0;
		else
			case ({ar_hs && !pending_redirect, fifo_rd})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
	end

	// Throttle against the fetch limit
	assign req_load = {1'b0, fill} + (LGDEPTH+1)'(o_m_axi_arvalid)
		+ (LGDEPTH+1)'(o_valid);
	assign throttle = (req_load >= FETCH_LIMIT) || fifo_full;

	////////////////////
	// Read address
	////////////////////

	// Idle until first redirect
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			fetch_en <= 1'b0;
		else if (i_new_pc)
			fetch_en <= 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			o_m_axi_arvalid <= 1'b0;
		else if (!o_m_axi_arvalid || i_m_axi_arready)
		begin
			if (i_new_pc || pending_redirect)
				o_m_axi_arvalid <= 1'b1;
			else
				o_m_axi_arvalid <= fetch_en && !throttle && !full_bus;
		end
	end

	// Redirect while ARVALID stalled, new address waits
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			pending_redirect <= 1'b0;
		else if (!o_m_axi_arvalid || i_m_axi_arready)
			pending_redirect <= 1'b0;
		else if (i_new_pc)
			pending_redirect <= 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_new_pc)
			pending_pc <= i_pc;
	end

	// Word steps of four
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_m_axi_arvalid || i_m_axi_arready)
		begin
			if (i_new_pc)
				o_m_axi_araddr <= i_pc;
			else if (pending_redirect)
				o_m_axi_araddr <= pending_pc;
			else if (o_m_axi_arvalid)
				o_m_axi_araddr <= {o_m_axi_araddr[ADDR_W-1:2] + 1'b1, 2'b00};
		end
	end

	// Word buffer, error bit on top
	insn_fifo u_fifo (
		.S_AXI_ACLK (S_AXI_ACLK),
		.i_flush    (fifo_clear),
		.i_wr       (fifo_wr),
		.i_data     ({i_m_axi_rresp[1], i_m_axi_rdata}),
		.i_rd       (fifo_rd),
		.o_data     (fifo_rd_data),
		.o_empty    (fifo_empty),
		.o_full     (fifo_full)
	);

	////////////////////
	// Output register
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_clear)
			o_valid <= 1'b0;
		else if (!o_valid || i_ready)
			o_valid <= !fifo_empty;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_rd)
		begin
			out_insn <= fifo_rd_data[DATA_W-1:0];
			out_err <= fifo_rd_data[DATA_W];
		end
	end

	// PC of the presented word
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_new_pc)
			out_pc <= i_pc;
		else if (o_valid && i_ready)
			out_pc <= out_pc + 32'd4;
	end

	always_comb
	begin
		o_word.insn = out_insn;
		o_word.pc = out_pc;
		o_word.err = out_err;
	end

	// AXI rule, address held until accepted
	a_araddr_stable: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		(o_m_axi_arvalid && !i_m_axi_arready)
		|=> (o_m_axi_arvalid && $stable(o_m_axi_araddr)));

	// No response without a request behind it
	a_no_underflow: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		i_m_axi_rvalid |-> (outstanding != '0));

endmodule

/* hw/insn_decode.sv */
`timescale 1ns/1ps
// Registered decode, splits a fetched word into opcode, registers and sign-extended immediate
module insn_decode
	import fetch_pkg::*;
(
	input  logic        S_AXI_ACLK,
	input  logic        fifo_reset,
	input  logic        i_squash,
	input  logic        i_stall,
	input  fetch_word_t i_word,
	input  logic        i_valid,
	output logic        o_ready,
	output decoded_t    o_dec
);

	opcode_e op_dec;

	// Ready unless the machine has stopped
	assign o_ready = !i_stall;

	// Unknown codes become NOP
	always_comb
	begin
		case (i_word.insn[31:28])
			4'h1: op_dec = OP_LDI;
			4'h2: op_dec = OP_ADDI;
			4'h3: op_dec = OP_ADD;
			4'h4: op_dec = OP_SUB;
			4'h5: op_dec = OP_XOR;
			4'h6: op_dec = OP_JMP;
			4'h7: op_dec = OP_BNZ;
			4'h8: op_dec = OP_HALT;
			default: op_dec = OP_NOP;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		// Fields only move with an accepted word
		if (!i_stall && i_valid)
		begin
			o_dec.op <= op_dec;
			o_dec.rd <= i_word.insn[27:26];
			o_dec.rs <= i_word.insn[25:24];
			o_dec.imm <= {{(DATA_W-16){i_word.insn[15]}}, i_word.insn[15:0]};
			o_dec.pc <= i_word.pc;
			o_dec.err <= i_word.err;
		end

		// Squash wins over hold
		if (fifo_reset || i_squash)
			o_dec.valid <= 1'b0;
		else if (!i_stall)
			o_dec.valid <= i_valid;
	end

	// Nothing from the old stream survives a redirect
	a_squash_clears: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		i_squash |=> (!o_dec.valid && !i_valid));

endmodule

/* hw/alu_execute.sv */
`timescale 1ns/1ps
// Execute stage, ALU with result bypass, jump and branch resolution, halt and trap
module alu_execute
	import fetch_pkg::*;
(
	input  logic              S_AXI_ACLK,
	input  logic              fifo_reset,
	input  decoded_t          i_dec,
	input  logic [DATA_W-1:0] i_rd_val,
	input  logic [DATA_W-1:0] i_rs_val,
	output logic [REG_W-1:0]  o_rd_sel,
	output logic [REG_W-1:0]  o_rs_sel,
	output logic              o_new_pc,
	output logic [ADDR_W-1:0] o_new_pc_addr,
	output retire_t           o_retire,
	output cpu_state_e        o_stop
);

	cpu_state_e        state;
	retire_t           ret_q;
	logic [DATA_W-1:0] rd_v;
	logic [DATA_W-1:0] rs_v;
	logic [DATA_W-1:0] alu_out;
	logic              alu_we;
	logic              taken;
	logic              go;

	assign o_rd_sel = i_dec.rd;
	assign o_rs_sel = i_dec.rs;

	////////////////////
	// Operand bypass
	////////////////////

	// Last result not yet in the register file
	assign rd_v = (ret_q.valid && ret_q.we && (ret_q.rd == i_dec.rd))
		? ret_q.value : i_rd_val;
	assign rs_v = (ret_q.valid && ret_q.we && (ret_q.rd == i_dec.rs))
		? ret_q.value : i_rs_val;

	// Work only while running
	assign go = i_dec.valid && (state == ST_RUN);

	always_comb
	begin
		alu_out = '0;
		alu_we = 1'b0;
		taken = 1'b0;
		case (i_dec.op)
			OP_LDI:
			begin
				alu_out = i_dec.imm;
				alu_we = 1'b1;
			end
			OP_ADDI:
			begin
				alu_out = rd_v + i_dec.imm;
				alu_we = 1'b1;
			end
			OP_ADD:
			begin
				alu_out = rd_v + rs_v;
				alu_we = 1'b1;
			end
			OP_SUB:
			begin
				alu_out = rd_v - rs_v;
				alu_we = 1'b1;
			end
			OP_XOR:
			begin
				alu_out = rd_v ^ rs_v;
				alu_we = 1'b1;
			end
			OP_JMP: taken = 1'b1;
			// Branch on register not zero
			OP_BNZ: taken = (rd_v != '0);
			default: alu_out = '0;
		endcase
	end

	// Redirect pulse, same cycle as the jump, also squashes decode
	assign o_new_pc = go && taken && !i_dec.err;
	assign o_new_pc_addr = ADDR_W'(i_dec.imm);

	////////////////////
	// Retire register
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		ret_q.pc <= i_dec.pc;
		ret_q.rd <= i_dec.rd;
		ret_q.value <= alu_out;
		ret_q.op <= i_dec.op;
		// Trapped word writes nothing
		ret_q.we <= alu_we && !i_dec.err;

		if (fifo_reset)
			ret_q.valid <= 1'b0;
		else
			ret_q.valid <= go && !i_dec.err;
	end

	// Stop state, only reset leaves it
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			state <= ST_RUN;
		else if (go && i_dec.err)
			state <= ST_TRAP;
		else if (go && (i_dec.op == OP_HALT))
			state <= ST_HALTED;
	end

	assign o_retire = ret_q;
	assign o_stop = state;

	// Once stopped, nothing more retires
	a_no_retire_stopped: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		(state != ST_RUN) |=> !o_retire.valid);

endmodule

/* hw/result_regfile.sv */
`timescale 1ns/1ps
// Result stage with the register file and the retire report
module result_regfile
	import fetch_pkg::*;
(
	input  logic              S_AXI_ACLK,
	input  logic              fifo_reset,
	input  retire_t           i_retire,
	input  logic [REG_W-1:0]  i_rd_sel,
	input  logic [REG_W-1:0]  i_rs_sel,
	output logic [DATA_W-1:0] o_rd_val,
	output logic [DATA_W-1:0] o_rs_val,
	output retire_t           o_retire
);

	logic [DATA_W-1:0] regs [NREGS];

	////////////////////
	// Register file
	////////////////////

	// Registers start at zero
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end
		else if (i_retire.valid && i_retire.we)
			regs[i_retire.rd] <= i_retire.value;
	end

	// Asynchronous read ports
	assign o_rd_val = regs[i_rd_sel];
	assign o_rs_val = regs[i_rs_sel];

	// Report goes out the cycle it arrives
	assign o_retire = i_retire;

endmodule

/* hw/fetch_exec_top.sv */
`timescale 1ns/1ps
// Fetch and execute subsystem with an AXI-lite instruction read port
module fetch_exec_top
	import fetch_pkg::*;
(
	input  logic              S_AXI_ACLK,
	input  logic              fifo_reset,
	input  logic              i_start,
	input  logic [ADDR_W-1:0] i_start_pc,
	output logic              o_m_axi_arvalid,
	input  logic              i_m_axi_arready,
	output logic [ADDR_W-1:0] o_m_axi_araddr,
	input  logic              i_m_axi_rvalid,
	output logic              o_m_axi_rready,
	input  logic [DATA_W-1:0] i_m_axi_rdata,
	input  logic [1:0]        i_m_axi_rresp,
	output retire_t           o_retire,
	output cpu_state_e        o_state
);

	logic              new_pc;
	logic [ADDR_W-1:0] new_pc_addr;
	logic              exec_new_pc;
	logic [ADDR_W-1:0] exec_new_pc_addr;
	fetch_word_t       fetch_word;
	logic              fetch_valid;
	logic              decode_ready;
	decoded_t          dec;
	logic [REG_W-1:0]  rd_sel;
	logic [REG_W-1:0]  rs_sel;
	logic [DATA_W-1:0] rd_val;
	logic [DATA_W-1:0] rs_val;
	retire_t           exec_retire;

	// Redirect from start or a taken jump
	assign new_pc = i_start || exec_new_pc;
	assign new_pc_addr = i_start ? i_start_pc : exec_new_pc_addr;

	axil_fetch u_fetch (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.fifo_reset      (fifo_reset),
		.i_new_pc        (new_pc),
		.i_pc            (new_pc_addr),
		.i_ready         (decode_ready),
		.o_word          (fetch_word),
		.o_valid         (fetch_valid),
		.o_m_axi_arvalid (o_m_axi_arvalid),
		.i_m_axi_arready (i_m_axi_arready),
		.o_m_axi_araddr  (o_m_axi_araddr),
		.i_m_axi_rvalid  (i_m_axi_rvalid),
		.o_m_axi_rready  (o_m_axi_rready),
		.i_m_axi_rdata   (i_m_axi_rdata),
		.i_m_axi_rresp   (i_m_axi_rresp)
	);

	// Stall once halted or trapped
	insn_decode u_decode (
		.S_AXI_ACLK (S_AXI_ACLK),
		.fifo_reset (fifo_reset),
		.i_squash   (new_pc),
		.i_stall    (o_state != ST_RUN),
		.i_word     (fetch_word),
		.i_valid    (fetch_valid),
		.o_ready    (decode_ready),
		.o_dec      (dec)
	);

	alu_execute u_exec (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.fifo_reset    (fifo_reset),
		.i_dec         (dec),
		.i_rd_val      (rd_val),
		.i_rs_val      (rs_val),
		.o_rd_sel      (rd_sel),
		.o_rs_sel      (rs_sel),
		.o_new_pc      (exec_new_pc),
		.o_new_pc_addr (exec_new_pc_addr),
		.o_retire      (exec_retire),
		.o_stop        (o_state)
	);

	result_regfile u_result (
		.S_AXI_ACLK (S_AXI_ACLK),
		.fifo_reset (fifo_reset),
		.i_retire   (exec_retire),
		.i_rd_sel   (rd_sel),
		.i_rs_sel   (rs_sel),
		.o_rd_val   (rd_val),
		.o_rs_val   (rs_val),
		.o_retire   (o_retire)
	);

endmodule

/* sim/axil_rom_model.sv */
// AXI-lite read-only program memory with random ready and response delays and one error address
`timescale 1ns/1ps
module axil_rom_model
	import fetch_pkg::*;
(
	input  logic              S_AXI_ACLK,
	input  logic              fifo_reset,
	input  logic              i_arvalid,
	output logic              o_arready,
	input  logic [ADDR_W-1:0] i_araddr,
	output logic              o_rvalid,
	output logic [DATA_W-1:0] o_rdata,
	output logic [1:0]        o_rresp
);

	// Word at this address answers SLVERR
	localparam logic [ADDR_W-1:0] ERR_ADDR = 32'h108;
	localparam int unsigned WORDS = 256;

	logic [DATA_W-1:0] mem [WORDS];
	// Accepted addresses waiting for their beat
	logic [ADDR_W-1:0] pend_q [$];
	logic [ADDR_W-1:0] rd_addr;
	logic [31:0]       lcg;
	logic [1:0]        ar_wait;
	logic [1:0]        r_wait;

	function automatic logic [31:0] next_lcg(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Instruction word, opcode rd rs then imm in the low half
	function automatic logic [DATA_W-1:0] enc(input opcode_e op, input logic [1:0] rd,
		input logic [1:0] rs, input logic [15:0] imm);
		return {op, rd, rs, 8'h00, imm};
	endfunction

	task automatic place(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] word);
		mem[addr[9:2]] = word;
	endtask

	initial
	begin
		lcg = 32'd94;
		o_arready = 1'b0;
		o_rvalid = 1'b0;
		o_rdata = '0;
		o_rresp = 2'b00;
		ar_wait = 2'd0;
		r_wait = 2'd0;
		// Filler, LDI r3 with its own byte address as immediate
		for (int i = 0; i < WORDS; i++)
			mem[i] = enc(OP_LDI, 2'd3, 2'd0, 16'(i * 4));

		////////////////////
		// Run 1 from 0x000
		////////////////////
		place(32'h000, enc(OP_LDI, 2'd0, 2'd0, 16'd5));
		place(32'h004, enc(OP_ADDI, 2'd0, 2'd0, 16'd3));
		place(32'h008, enc(OP_LDI, 2'd1, 2'd0, 16'hFFFE));
		place(32'h00C, enc(OP_ADD, 2'd0, 2'd1, 16'd0));
		place(32'h010, enc(OP_SUB, 2'd1, 2'd0, 16'd0));
		place(32'h014, enc(OP_XOR, 2'd1, 2'd0, 16'd0));
		place(32'h018, enc(OP_JMP, 2'd0, 2'd0, 16'h0030));
		// Shadow of the jump, must never retire
		place(32'h01C, enc(OP_LDI, 2'd2, 2'd0, 16'h0077));
		place(32'h030, enc(OP_LDI, 2'd2, 2'd0, 16'd0));
		// r2 is zero so this falls through
		place(32'h034, enc(OP_BNZ, 2'd2, 2'd0, 16'h001C));
		place(32'h038, enc(OP_LDI, 2'd3, 2'd0, 16'd3));
		// Countdown loop on r3
		place(32'h03C, enc(OP_ADDI, 2'd3, 2'd0, 16'hFFFF));
		place(32'h040, enc(OP_BNZ, 2'd3, 2'd0, 16'h003C));
		place(32'h044, enc(OP_LDI, 2'd0, 2'd0, 16'h1234));
		place(32'h048, enc(OP_HALT, 2'd0, 2'd0, 16'd0));
		place(32'h04C, enc(OP_LDI, 2'd1, 2'd0, 16'h0055));

		////////////////////
		// Run 2 from 0x100
		////////////////////
		place(32'h100, enc(OP_LDI, 2'd1, 2'd0, 16'd7));
		place(32'h104, enc(OP_ADDI, 2'd1, 2'd0, 16'd1));
		place(32'h108, enc(OP_ADD, 2'd1, 2'd1, 16'd0));
		place(32'h10C, enc(OP_LDI, 2'd2, 2'd0, 16'd1));
	end

	always @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			o_arready <= 1'b0;
			o_rvalid <= 1'b0;
			ar_wait <= 2'd0;
			r_wait <= 2'd0;
			pend_q.delete();
		end
		else
		begin
			// One R beat per queued address, in order
			o_rvalid <= 1'b0;
			if (pend_q.size() != 0)
			begin
				if (r_wait == 2'd0)
				begin
					rd_addr = pend_q.pop_front();
					o_rvalid <= 1'b1;
					o_rdata <= mem[rd_addr[9:2]];
					o_rresp <= (rd_addr == ERR_ADDR) ? 2'b10 : 2'b00;
					lcg = next_lcg(lcg);
					r_wait <= lcg[17:16];
				end
				else
					r_wait <= r_wait - 1'b1;
			end
			// Ready returns 0 to 3 cycles after each accept
			if (i_arvalid && o_arready)
			begin
				pend_q.push_back(i_araddr);
				lcg = next_lcg(lcg);
				ar_wait <= lcg[17:16];
				o_arready <= (lcg[17:16] == 2'd0);
			end
			else if (ar_wait != 2'd0)
			begin
				ar_wait <= ar_wait - 1'b1;
				o_arready <= (ar_wait == 2'd1);
			end
			else
				o_arready <= 1'b1;
		end
	end

endmodule

/* sim/tb_fetch_exec.sv */
// Testbench for the fetch and execute subsystem, walks an expected retire table over two runs
`timescale 1ns/1ps
module tb_fetch_exec
	import fetch_pkg::*;
();

	// Cycle limits for every wait
	localparam int unsigned TIMEOUT = 300;
	localparam int unsigned QUIET = 50;

	// Expected retire entry
	typedef struct packed {
		logic [ADDR_W-1:0] pc;
		opcode_e           op;
		logic [REG_W-1:0]  rd;
		logic              we;
		logic [DATA_W-1:0] value;
	} exp_t;

	logic              S_AXI_ACLK;
	logic              fifo_reset;
	logic              i_start;
	logic [ADDR_W-1:0] i_start_pc;
	logic              m_axi_arvalid;
	logic              m_axi_arready;
	logic [ADDR_W-1:0] m_axi_araddr;
	logic              m_axi_rvalid;
	logic              m_axi_rready;
	logic [DATA_W-1:0] m_axi_rdata;
	logic [1:0]        m_axi_rresp;
	retire_t           retire;
	cpu_state_e        state;

	exp_t              exp_tab [$];
	int                run1_len;
	int unsigned       err_count;

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever
			#10 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	fetch_exec_top dut_i (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.fifo_reset      (fifo_reset),
		.i_start         (i_start),
		.i_start_pc      (i_start_pc),
		.o_m_axi_arvalid (m_axi_arvalid),
		.i_m_axi_arready (m_axi_arready),
		.o_m_axi_araddr  (m_axi_araddr),
		.i_m_axi_rvalid  (m_axi_rvalid),
		.o_m_axi_rready  (m_axi_rready),
		.i_m_axi_rdata   (m_axi_rdata),
		.i_m_axi_rresp   (m_axi_rresp),
		.o_retire        (retire),
		.o_state         (state)
	);

	axil_rom_model u_rom (
		.S_AXI_ACLK (S_AXI_ACLK),
		.fifo_reset (fifo_reset),
		.i_arvalid  (m_axi_arvalid),
		.o_arready  (m_axi_arready),
		.i_araddr   (m_axi_araddr),
		.o_rvalid   (m_axi_rvalid),
		.o_rdata    (m_axi_rdata),
		.o_rresp    (m_axi_rresp)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopping at first failure");
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
		begin
			err_count++;
			fail_run($sformatf("Error at %0t ns: %s is %h, expected %h",
				$time, name, got, want));
		end
	endtask

	task automatic table_entry(input logic [ADDR_W-1:0] pc, input opcode_e op,
		input logic [REG_W-1:0] rd, input logic we, input logic [DATA_W-1:0] value);
		exp_t e;
		e.pc = pc;
		e.op = op;
		e.rd = rd;
		e.we = we;
		e.value = value;
		exp_tab.push_back(e);
	endtask

	////////////////////
	// Expected retires
	////////////////////

	task automatic build_table();
		// Straight line, each result feeds the next
		table_entry(32'h000, OP_LDI, 2'd0, 1'b1, 32'd5);
		table_entry(32'h004, OP_ADDI, 2'd0, 1'b1, 32'd8);
		table_entry(32'h008, OP_LDI, 2'd1, 1'b1, 32'hFFFF_FFFE);
		// 8 + -2
		table_entry(32'h00C, OP_ADD, 2'd0, 1'b1, 32'd6);
		// -2 - 6
		table_entry(32'h010, OP_SUB, 2'd1, 1'b1, 32'hFFFF_FFF8);
		table_entry(32'h014, OP_XOR, 2'd1, 1'b1, 32'hFFFF_FFFE);
		// JMP writes nothing, next is the target
		table_entry(32'h018, OP_JMP, 2'd0, 1'b0, 32'd0);
		table_entry(32'h030, OP_LDI, 2'd2, 1'b1, 32'd0);
		table_entry(32'h034, OP_BNZ, 2'd2, 1'b0, 32'd0);
		table_entry(32'h038, OP_LDI, 2'd3, 1'b1, 32'd3);
		// Three passes, r3 goes 2 1 0
		table_entry(32'h03C, OP_ADDI, 2'd3, 1'b1, 32'd2);
		table_entry(32'h040, OP_BNZ, 2'd3, 1'b0, 32'd0);
		table_entry(32'h03C, OP_ADDI, 2'd3, 1'b1, 32'd1);
		table_entry(32'h040, OP_BNZ, 2'd3, 1'b0, 32'd0);
		table_entry(32'h03C, OP_ADDI, 2'd3, 1'b1, 32'd0);
		table_entry(32'h040, OP_BNZ, 2'd3, 1'b0, 32'd0);
		table_entry(32'h044, OP_LDI, 2'd0, 1'b1, 32'h0000_1234);
		table_entry(32'h048, OP_HALT, 2'd0, 1'b0, 32'd0);
		run1_len = exp_tab.size();
		// Second run, registers back at zero, stops at 0x108
		table_entry(32'h100, OP_LDI, 2'd1, 1'b1, 32'd7);
		table_entry(32'h104, OP_ADDI, 2'd1, 1'b1, 32'd8);
	endtask

	task automatic pulse_reset();
		@(posedge S_AXI_ACLK);
		fifo_reset <= 1'b1;
		repeat (16)
			@(posedge S_AXI_ACLK);
		fifo_reset <= 1'b0;
	endtask

	// First request goes out one cycle after start
	task automatic start_fetch(input logic [ADDR_W-1:0] pc);
		@(posedge S_AXI_ACLK);
		i_start <= 1'b1;
		i_start_pc <= pc;
		@(posedge S_AXI_ACLK);
		i_start <= 1'b0;
		@(negedge S_AXI_ACLK);
		compare_value("o_m_axi_arvalid", 32'(m_axi_arvalid), 32'd1);
		compare_value("o_m_axi_araddr", m_axi_araddr, pc);
	endtask

	// Next cycle with a retire, sampled mid-cycle
	task automatic await_retire();
		int unsigned cycles;
		cycles = 0;
		@(negedge S_AXI_ACLK);
		while (retire.valid !== 1'b1)
		begin
			if (cycles == TIMEOUT)
				fail_run("Timed out waiting for an instruction to retire");
			else
			begin
				cycles++;
				@(negedge S_AXI_ACLK);
			end
		end
	endtask

	task automatic walk_retires(input int first, input int last);
		exp_t e;
		for (int k = first; k < last; k++)
		begin
			e = exp_tab[k];
			await_retire();
			compare_value("o_retire.pc", retire.pc, e.pc);
			compare_value("o_retire.op", 32'(retire.op), 32'(e.op));
			compare_value("o_retire.rd", 32'(retire.rd), 32'(e.rd));
			compare_value("o_retire.we", 32'(retire.we), 32'(e.we));
			// Value only counts when written
			if (e.we)
				compare_value("o_retire.value", retire.value, e.value);
		end
	endtask

	// Nothing may retire while the stop is pending, nor as it shows
	task automatic poll_state(input cpu_state_e want);
		int unsigned cycles;
		cycles = 0;
		@(negedge S_AXI_ACLK);
		while (state !== want)
		begin
			compare_value("o_retire.valid", 32'(retire.valid), 32'd0);
			if (cycles == TIMEOUT)
				fail_run($sformatf("Timed out waiting for o_state to become %s", want.name()));
			else
			begin
				cycles++;
				@(negedge S_AXI_ACLK);
			end
		end
		compare_value("o_retire.valid", 32'(retire.valid), 32'd0);
	endtask

	task automatic hold_no_retire(input cpu_state_e want);
		repeat (QUIET)
		begin
			@(negedge S_AXI_ACLK);
			compare_value("o_retire.valid", 32'(retire.valid), 32'd0);
			compare_value("o_state", 32'(state), 32'(want));
		end
	endtask

	initial
	begin
		fifo_reset = 1'b1;
		i_start = 1'b0;
		i_start_pc = '0;
		err_count = 0;
		build_table();
		pulse_reset();

		// Idle before start, no requests and no retires
		repeat (10)
		begin
			@(negedge S_AXI_ACLK);
			compare_value("o_m_axi_arvalid", 32'(m_axi_arvalid), 32'd0);
			compare_value("o_m_axi_rready", 32'(m_axi_rready), 32'd1);
			compare_value("o_retire.valid", 32'(retire.valid), 32'd0);
			compare_value("o_state", 32'(state), 32'(ST_RUN));
		end

		// Run 1, ends in HALT
		start_fetch(32'h000);
		walk_retires(0, run1_len);
		poll_state(ST_HALTED);
		hold_no_retire(ST_HALTED);

		// Run 2, bus error at 0x108
		pulse_reset();
		@(negedge S_AXI_ACLK);
		compare_value("o_state", 32'(state), 32'(ST_RUN));
		start_fetch(32'h100);
		walk_retires(run1_len, exp_tab.size());
		poll_state(ST_TRAP);
		hold_no_retire(ST_TRAP);

		if (err_count == 0)
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
		else
			fail_run("Checks failed during the run");
	end

endmodule

/* fetch_exec_top.f */
common/fetch_pkg.sv
hw/fetch/insn_fifo.sv
hw/fetch/axil_fetch.sv
hw/insn_decode.sv
hw/alu_execute.sv
hw/result_regfile.sv
hw/fetch_exec_top.sv
sim/axil_rom_model.sv
sim/tb_fetch_exec.sv

/* Bender.yml */
package:
  name: fetch_exec_top

sources:
  - common/fetch_pkg.sv
  - hw/fetch/insn_fifo.sv
  - hw/fetch/axil_fetch.sv
  - hw/insn_decode.sv
  - hw/alu_execute.sv
  - hw/result_regfile.sv
  - hw/fetch_exec_top.sv
  - target: simulation
    files:
      - sim/axil_rom_model.sv
      - sim/tb_fetch_exec.sv
